/* include/jtag_dtm_macros.svh */
/*
 * JTAG debug transport constants
 * Instruction register length and codes, DMI widths, IDCODE value
 * and the size of the debug register target
 */

`ifndef JTAG_DTM_MACROS_SVH
`define JTAG_DTM_MACROS_SVH

// TAP instruction register
`define DTM_IR_LEN      5
`define DTM_IR_IDCODE   5'h01
`define DTM_IR_DTMCS    5'h10
`define DTM_IR_DMI      5'h11
`define DTM_IR_BYPASS   5'h1f

// Identification register contents
`define DTM_IDCODE      32'h1000_0a6f

// DMI address and data widths
`define DTM_ABITS       7
`define DTM_DATA_W      32

// Words in the debug register target, higher addresses fail
`define DTM_REG_COUNT   16

`endif

/* rtl/jtag_dtm_pkg.sv */
/*
 * JTAG debug transport types
 * TAP states, instruction codes, DMI operation and status fields,
 * and the structs passed between the TAP, the DR chain and the DMI
 */

`default_nettype none

`include "jtag_dtm_macros.svh"

package jtag_dtm_pkg;

    // IEEE 1149.1 controller states
    typedef enum logic [3:0] {
        TAP_RESET,
        TAP_IDLE,
        TAP_SEL_DR,
        TAP_CAP_DR,
        TAP_SHIFT_DR,
        TAP_EXIT1_DR,
        TAP_PAUSE_DR,
        TAP_EXIT2_DR,
        TAP_UPD_DR,
        TAP_SEL_IR,
        TAP_CAP_IR,
        TAP_SHIFT_IR,
        TAP_EXIT1_IR,
        TAP_PAUSE_IR,
        TAP_EXIT2_IR,
        TAP_UPD_IR
    } tap_state_e;

    // Unlisted codes select BYPASS
    typedef enum logic [`DTM_IR_LEN-1:0] {
        IR_IDCODE = `DTM_IR_IDCODE,
        IR_DTMCS  = `DTM_IR_DTMCS,
        IR_DMI    = `DTM_IR_DMI,
        IR_BYPASS = `DTM_IR_BYPASS
    } jtag_ir_e;

    typedef enum logic [1:0] {
        DMI_NOP   = 2'd0,
        DMI_READ  = 2'd1,
        DMI_WRITE = 2'd2
    } dmi_op_e;

    typedef enum logic [1:0] {
        DMI_OK     = 2'd0,
        DMI_FAILED = 2'd2,
        DMI_BUSY   = 2'd3
    } dmi_status_e;

    // One-cycle pulses from the TAP, plus the sampled TDI bit
    typedef struct packed {
        logic capture_dr;
        logic shift_dr;
        logic update_dr;
        logic tck_fall;
        logic tdi;
    } tap_strobe_t;

    // Same bit order as the DMI scan register, op at the LSB end
    typedef struct packed {
        logic [`DTM_ABITS-1:0]  addr;
        logic [`DTM_DATA_W-1:0] data;
        dmi_op_e                op;
    } dmi_req_t;

    typedef struct packed {
        logic [`DTM_DATA_W-1:0] data;
        dmi_status_e            status;
    } dmi_resp_t;

endpackage

`default_nettype wire

/* rtl/jtag_tap_ctrl.sv */
/*
 * JTAG TAP controller
 * Brings TCK, TMS and TDI into the clk domain, steps the 16-state
 * TAP FSM once per TCK rise and owns the instruction register.
 * DR strobes leave as registered one-cycle pulses, TDO moves on TCK fall.
 */

`timescale 1ns/1ps
`default_nettype none

`include "jtag_dtm_macros.svh"

module jtag_tap_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      tck_i,
    input  logic                      tms_i,
    input  logic                      tdi_i,
    input  logic                      dr_tdo_i,
    output logic                      tdo_o,
    output jtag_dtm_pkg::tap_strobe_t strobe_o,
    output jtag_dtm_pkg::jtag_ir_e    ir_o
);

    // Pin synchronizer stages, bit order {tck, tms, tdi}
    logic [2:0] sync0_q;
    logic [2:0] sync1_q;
    logic       tck_prev_q;
    logic       tck_s;
    logic       tms_s;
    logic       tdi_s;
    logic       tck_rise;
    logic       tck_fall;

    jtag_dtm_pkg::tap_state_e state_q;
    jtag_dtm_pkg::tap_state_e state_d;

    // IR shift stage, loaded into ir_o on Update-IR
    logic [`DTM_IR_LEN-1:0] ir_sr;

    ////////////////////
    // Pin sampling
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync0_q    <= '0;
            sync1_q    <= '0;
            tck_prev_q <= 1'b0;
        end else begin
            sync0_q    <= {tck_i, tms_i, tdi_i};
            sync1_q    <= sync0_q;
            tck_prev_q <= sync1_q[2];
        end
    end

    assign tck_s = sync1_q[2];
    assign tms_s = sync1_q[1];
    assign tdi_s = sync1_q[0];

    // Edge detect, third clk after the pin toggles
    assign tck_rise = tck_s && !tck_prev_q;
    assign tck_fall = !tck_s && tck_prev_q;

    ////////////////////
    // TAP state machine
    ////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            jtag_dtm_pkg::TAP_RESET:
                state_d = tms_s ? jtag_dtm_pkg::TAP_RESET : jtag_dtm_pkg::TAP_IDLE;
            jtag_dtm_pkg::TAP_IDLE:
                state_d = tms_s ? jtag_dtm_pkg::TAP_SEL_DR : jtag_dtm_pkg::TAP_IDLE;
            jtag_dtm_pkg::TAP_SEL_DR:
                state_d = tms_s ? jtag_dtm_pkg::TAP_SEL_IR : jtag_dtm_pkg::TAP_CAP_DR;
            jtag_dtm_pkg::TAP_CAP_DR,
            jtag_dtm_pkg::TAP_SHIFT_DR:
                state_d = tms_s ? jtag_dtm_pkg::TAP_EXIT1_DR : jtag_dtm_pkg::TAP_SHIFT_DR;
            jtag_dtm_pkg::TAP_EXIT1_DR:
                state_d = tms_s ? jtag_dtm_pkg::TAP_UPD_DR : jtag_dtm_pkg::TAP_PAUSE_DR;
            jtag_dtm_pkg::TAP_PAUSE_DR:
                state_d = tms_s ? jtag_dtm_pkg::TAP_EXIT2_DR : jtag_dtm_pkg::TAP_PAUSE_DR;
            jtag_dtm_pkg::TAP_EXIT2_DR:
                state_d = tms_s ? jtag_dtm_pkg::TAP_UPD_DR : jtag_dtm_pkg::TAP_SHIFT_DR;
            jtag_dtm_pkg::TAP_SEL_IR:
                state_d = tms_s ? jtag_dtm_pkg::TAP_RESET : jtag_dtm_pkg::TAP_CAP_IR;
            jtag_dtm_pkg::TAP_CAP_IR,
            jtag_dtm_pkg::TAP_SHIFT_IR:
                state_d = tms_s ? jtag_dtm_pkg::TAP_EXIT1_IR : jtag_dtm_pkg::TAP_SHIFT_IR;
            jtag_dtm_pkg::TAP_EXIT1_IR:
                state_d = tms_s ? jtag_dtm_pkg::TAP_UPD_IR : jtag_dtm_pkg::TAP_PAUSE_IR;
            jtag_dtm_pkg::TAP_PAUSE_IR:
                state_d = tms_s ? jtag_dtm_pkg::TAP_EXIT2_IR : jtag_dtm_pkg::TAP_PAUSE_IR;
            jtag_dtm_pkg::TAP_EXIT2_IR:
                state_d = tms_s ? jtag_dtm_pkg::TAP_UPD_IR : jtag_dtm_pkg::TAP_SHIFT_IR;
            // Both update states leave the same way
            default:
                state_d = tms_s ? jtag_dtm_pkg::TAP_SEL_DR : jtag_dtm_pkg::TAP_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= jtag_dtm_pkg::TAP_RESET;
            ir_o     <= jtag_dtm_pkg::IR_IDCODE;
            strobe_o <= '0;
            tdo_o    <= 1'b0;
        end else begin
            // DR actions belong to the state being left on this rise
            strobe_o.capture_dr <= tck_rise && (state_q == jtag_dtm_pkg::TAP_CAP_DR);
            strobe_o.shift_dr   <= tck_rise && (state_q == jtag_dtm_pkg::TAP_SHIFT_DR);
            strobe_o.update_dr  <= tck_rise && (state_q == jtag_dtm_pkg::TAP_UPD_DR);
            strobe_o.tck_fall   <= tck_fall;
            strobe_o.tdi        <= tdi_s;
            if (tck_rise) begin
                state_q <= state_d;
                if (state_q == jtag_dtm_pkg::TAP_RESET) begin
                    ir_o <= jtag_dtm_pkg::IR_IDCODE;
                end else if (state_q == jtag_dtm_pkg::TAP_UPD_IR) begin
                    // Unused codes are kept, the chain treats them as BYPASS
                    ir_o <= jtag_dtm_pkg::jtag_ir_e'(ir_sr);
                end
            end
            // IR bit while in Shift-IR, DR bit otherwise
            if (tck_fall) begin
                tdo_o <= (state_q == jtag_dtm_pkg::TAP_SHIFT_IR) ? ir_sr[0] : dr_tdo_i;
            end
        end
    end

    // Capture-IR loads the mandatory 01 pattern
    always_ff @(posedge clk) begin
        if (tck_rise) begin
            if (state_q == jtag_dtm_pkg::TAP_CAP_IR) begin
                ir_sr <= `DTM_IR_LEN'(2'b01);
            end else if (state_q == jtag_dtm_pkg::TAP_SHIFT_IR) begin
                ir_sr <= {tdi_s, ir_sr[`DTM_IR_LEN-1:1]};
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/jtag_dr_chain.sv */
/*
 * JTAG data register chain
 * IDCODE, BYPASS, DTMCS and DMI scan registers selected by the IR.
 * Update of DMI emits a request, update of DTMCS can pulse dmireset
 */

`timescale 1ns/1ps
`default_nettype none

`include "jtag_dtm_macros.svh"

module jtag_dr_chain (
    input  logic                      clk,
    input  logic                      rst_n,
    input  jtag_dtm_pkg::tap_strobe_t strobe_i,
    input  jtag_dtm_pkg::jtag_ir_e    ir_i,
    input  jtag_dtm_pkg::dmi_resp_t   resp_i,
    input  logic                      busy_i,
    input  jtag_dtm_pkg::dmi_status_e sticky_i,
    output logic                      dr_tdo_o,
    output logic                      dmi_update_o,
    output logic                      dmi_reset_o,
    output jtag_dtm_pkg::dmi_req_t    req_o
);

    localparam int DMI_W = $bits(jtag_dtm_pkg::dmi_req_t);

    logic                sel_idcode;
    logic                sel_dtmcs;
    logic                sel_dmi;
    logic                sel_bypass;

    logic [31:0]         idcode_sr;
    logic                bypass_sr;
    logic [31:0]         dtmcs_sr;
    logic [DMI_W-1:0]    dmi_sr;

    logic [31:0]         dtmcs_cap;
    logic [DMI_W-1:0]    dmi_cap;
    jtag_dtm_pkg::dmi_status_e cap_status;

    // Anything not decoded falls back to BYPASS
    assign sel_idcode = (ir_i == jtag_dtm_pkg::IR_IDCODE);
    assign sel_dtmcs  = (ir_i == jtag_dtm_pkg::IR_DTMCS);
    assign sel_dmi    = (ir_i == jtag_dtm_pkg::IR_DMI);
    assign sel_bypass = !(sel_idcode || sel_dtmcs || sel_dmi);

    ////////////////////
    // Capture values
    ////////////////////

    // Outstanding request reads back as BUSY
    assign cap_status = busy_i ? jtag_dtm_pkg::DMI_BUSY : sticky_i;

    // idle 1, dmistat, abits, version 1
    assign dtmcs_cap = {17'd0, 3'd1, sticky_i, 6'(`DTM_ABITS), 4'd1};
    assign dmi_cap   = {req_o.addr, resp_i.data, cap_status};

    ////////////////////
    // Scan registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (strobe_i.capture_dr) begin
            idcode_sr <= `DTM_IDCODE;
            bypass_sr <= 1'b0;
            dtmcs_sr  <= dtmcs_cap;
            dmi_sr    <= dmi_cap;
        end else if (strobe_i.shift_dr) begin
            // LSB first, only the selected register moves
            if (sel_idcode) begin
                idcode_sr <= {strobe_i.tdi, idcode_sr[31:1]};
            end
            if (sel_bypass) begin
                bypass_sr <= strobe_i.tdi;
            end
            if (sel_dtmcs) begin
                dtmcs_sr <= {strobe_i.tdi, dtmcs_sr[31:1]};
            end
            if (sel_dmi) begin
                dmi_sr <= {strobe_i.tdi, dmi_sr[DMI_W-1:1]};
            end
        end
    end

    ////////////////////
    // Update side
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dmi_update_o <= 1'b0;
            dmi_reset_o  <= 1'b0;
            req_o        <= '0;
        end else begin
            dmi_update_o <= strobe_i.update_dr && sel_dmi;
            // Bit 16 of DTMCS is dmireset
            dmi_reset_o  <= strobe_i.update_dr && sel_dtmcs && dtmcs_sr[16];
            if (strobe_i.update_dr && sel_dmi) begin
                req_o <= jtag_dtm_pkg::dmi_req_t'(dmi_sr);
            end
        end
    end

    // Serial output of the selected register
    always_comb begin
        if (sel_idcode) begin
            dr_tdo_o = idcode_sr[0];
        end else if (sel_dtmcs) begin
            dr_tdo_o = dtmcs_sr[0];
        end else if (sel_dmi) begin
            dr_tdo_o = dmi_sr[0];
        end else begin
            dr_tdo_o = bypass_sr;
        end
    end

endmodule

`default_nettype wire

/* rtl/dmi_master.sv */
/*
 * DMI master
 * Turns a DMI scan update into a valid/ready request, keeps the
 * response for the next capture and tracks busy and sticky status
 */

`timescale 1ns/1ps
`default_nettype none

module dmi_master (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      dmi_update_i,
    input  logic                      dmi_reset_i,
    input  jtag_dtm_pkg::dmi_req_t    req_i,
    output logic                      req_valid_o,
    input  logic                      req_ready_i,
    output jtag_dtm_pkg::dmi_req_t    dm_req_o,
    input  logic                      resp_valid_i,
    output logic                      resp_ready_o,
    input  jtag_dtm_pkg::dmi_resp_t   dm_resp_i,
    output jtag_dtm_pkg::dmi_resp_t   resp_o,
    output logic                      busy_o,
    output jtag_dtm_pkg::dmi_status_e sticky_o
);

    logic issue;

    // Responses are always taken at once
    assign resp_ready_o = 1'b1;

    // NOP updates only refresh the scan address
    assign issue = dmi_update_i && (req_i.op != jtag_dtm_pkg::DMI_NOP);

    // Request payload, stable while valid is high
    always_ff @(posedge clk) begin
        if (issue && !busy_o) begin
            dm_req_o <= req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_valid_o <= 1'b0;
            busy_o      <= 1'b0;
            resp_o      <= '0;
            sticky_o    <= jtag_dtm_pkg::DMI_OK;
        end else begin
            // Handshake done, drop valid
            if (req_valid_o && req_ready_i) begin
                req_valid_o <= 1'b0;
            end
            if (resp_valid_i) begin
                resp_o <= dm_resp_i;
                busy_o <= 1'b0;
                if (dm_resp_i.status == jtag_dtm_pkg::DMI_FAILED) begin
                    sticky_o <= jtag_dtm_pkg::DMI_FAILED;
                end
            end
            if (issue) begin
                if (busy_o) begin
                    // Overrun, request is lost
                    sticky_o <= jtag_dtm_pkg::DMI_BUSY;
                end else begin
                    req_valid_o <= 1'b1;
                    busy_o      <= 1'b1;
                end
            end
            // dmireset is the only way back to OK
            if (dmi_reset_i) begin
                sticky_o <= jtag_dtm_pkg::DMI_OK;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/dm_regfile.sv */
/*
 * Debug module register file
 * 16 words behind the DMI, one request accepted at a time,
 * out-of-range addresses answer FAILED
 */

`timescale 1ns/1ps
`default_nettype none

`include "jtag_dtm_macros.svh"

module dm_regfile (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  jtag_dtm_pkg::dmi_req_t  req_i,
    output logic                    resp_valid_o,
    input  logic                    resp_ready_i,
    output jtag_dtm_pkg::dmi_resp_t resp_o
);

    localparam int IDX_W = $clog2(`DTM_REG_COUNT);

    logic [`DTM_DATA_W-1:0] mem_q [`DTM_REG_COUNT];
    logic                   accept;
    logic                   in_range;
    logic [IDX_W-1:0]       idx;

    // Ready while no response waits
    assign req_ready_o = !resp_valid_o;
    assign accept      = req_valid_i && req_ready_o;
    assign in_range    = req_i.addr < `DTM_REG_COUNT;
    assign idx         = req_i.addr[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid_o <= 1'b0;
            resp_o       <= '0;
            for (int i = 0; i < `DTM_REG_COUNT; i++) begin
                mem_q[i] <= '0;
            end
        end else begin
            if (resp_valid_o && resp_ready_i) begin
                resp_valid_o <= 1'b0;
            end
            if (accept) begin
                resp_valid_o <= 1'b1;
                if (!in_range) begin
                    resp_o.data   <= '0;
                    resp_o.status <= jtag_dtm_pkg::DMI_FAILED;
                end else begin
                    resp_o.status <= jtag_dtm_pkg::DMI_OK;
                    // Writes echo the stored data
                    if (req_i.op == jtag_dtm_pkg::DMI_WRITE) begin
                        mem_q[idx]  <= req_i.data;
                        resp_o.data <= req_i.data;
                    end else begin
                        resp_o.data <= mem_q[idx];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/jtag_dtm_top.sv */
/*
 * JTAG debug transport top
 * TAP controller, DR chain, DMI master and debug register file
 */

`timescale 1ns/1ps
`default_nettype none

module jtag_dtm_top (
    input  logic clk,
    input  logic rst_n,
    input  logic tck_i,
    input  logic tms_i,
    input  logic tdi_i,
    output logic tdo_o
);

    // TAP to chain
    jtag_dtm_pkg::tap_strobe_t strobe;
    jtag_dtm_pkg::jtag_ir_e    ir;
    logic                      dr_tdo;

    // Chain to DMI master
    logic                      dmi_update;
    logic                      dmi_reset;
    jtag_dtm_pkg::dmi_req_t    scan_req;
    jtag_dtm_pkg::dmi_resp_t   scan_resp;
    logic                      busy;
    jtag_dtm_pkg::dmi_status_e sticky;

    // DMI bus
    logic                      req_valid;
    logic                      req_ready;
    jtag_dtm_pkg::dmi_req_t    dm_req;
    logic                      resp_valid;
    logic                      resp_ready;
    jtag_dtm_pkg::dmi_resp_t   dm_resp;

    jtag_tap_ctrl u_tap (
        .clk      (clk),
        .rst_n    (rst_n),
        .tck_i    (tck_i),
        .tms_i    (tms_i),
        .tdi_i    (tdi_i),
        .dr_tdo_i (dr_tdo),
        .tdo_o    (tdo_o),
        .strobe_o (strobe),
        .ir_o     (ir)
    );

    jtag_dr_chain u_chain (
        .clk          (clk),
        .rst_n        (rst_n),
        .strobe_i     (strobe),
        .ir_i         (ir),
        .resp_i       (scan_resp),
        .busy_i       (busy),
        .sticky_i     (sticky),
        .dr_tdo_o     (dr_tdo),
        .dmi_update_o (dmi_update),
        .dmi_reset_o  (dmi_reset),
        .req_o        (scan_req)
    );

    dmi_master u_dmi (
        .clk          (clk),
        .rst_n        (rst_n),
        .dmi_update_i (dmi_update),
        .dmi_reset_i  (dmi_reset),
        .req_i        (scan_req),
        .req_valid_o  (req_valid),
        .req_ready_i  (req_ready),
        .dm_req_o     (dm_req),
        .resp_valid_i (resp_valid),
        .resp_ready_o (resp_ready),
        .dm_resp_i    (dm_resp),
        .resp_o       (scan_resp),
        .busy_o       (busy),
        .sticky_o     (sticky)
    );

    dm_regfile u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (req_valid),
        .req_ready_o  (req_ready),
        .req_i        (dm_req),
        .resp_valid_o (resp_valid),
        .resp_ready_i (resp_ready),
        .resp_o       (dm_resp)
    );

endmodule

`default_nettype wire

/* verification/jtag_dtm_assertions.sv */
/*
 * JTAG DTM protocol assertions
 * DMI request hold under back-pressure and TAP strobe sanity,
 * bound into the DTM top where both buses are visible
 */

`timescale 1ns/1ps
`default_nettype none

module jtag_dtm_assertions (
    input logic                      clk,
    input logic                      rst_n,
    input jtag_dtm_pkg::tap_strobe_t strobe_i,
    input logic                      req_valid_i,
    input logic                      req_ready_i,
    input jtag_dtm_pkg::dmi_req_t    dm_req_i
);

    // Valid and payload hold until the register file takes them
    req_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_valid_i && !req_ready_i |=> req_valid_i && $stable(dm_req_i)
    ) else $error("DMI request dropped or changed before ready");

    // Strobes stay quiet while reset is applied
    strobe_reset: assert property (
        @(posedge clk) !rst_n |=> strobe_i == '0
    ) else $error("TAP strobe asserted during reset");

    // Capture-DR and Shift-DR are different TAP states
    capture_shift_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(strobe_i.capture_dr && strobe_i.shift_dr)
    ) else $error("capture_dr and shift_dr high in the same cycle");

endmodule

bind jtag_dtm_top jtag_dtm_assertions u_dtm_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .strobe_i    (strobe),
    .req_valid_i (req_valid),
    .req_ready_i (req_ready),
    .dm_req_i    (dm_req)
);

`default_nettype wire

/* verification/jtag_dtm_tb.sv */
/*
 * JTAG DTM testbench
 * Bit-bangs TCK/TMS/TDI against the DTM top, scans IDCODE, BYPASS,
 * DTMCS and DMI, and checks DMI traffic against a register model
 */

`timescale 1ns/1ps
`default_nettype none

`include "jtag_dtm_macros.svh"

module jtag_dtm_tb;

    localparam int HALF_TCK     = 8;
    localparam int RST_CYCLES   = 8;
    localparam int DMI_W        = $bits(jtag_dtm_pkg::dmi_req_t);
    localparam int IDX_W        = $clog2(`DTM_REG_COUNT);
    localparam int BUSY_RETRIES = 8;
    localparam int NUM_ACCESS   = 20;

    logic clk;
    logic rst_n;
    logic tck;
    logic tms;
    logic tdi;
    logic tdo;

    logic [31:0]               lfsr_q;
    logic [`DTM_DATA_W-1:0]    model_mem [`DTM_REG_COUNT];
    jtag_dtm_pkg::dmi_status_e model_sticky;

    jtag_dtm_top u_jtag_dtm_top (
        .clk   (clk),
        .rst_n (rst_n),
        .tck_i (tck),
        .tms_i (tms),
        .tdi_i (tdi),
        .tdo_o (tdo)
    );

    // 4 ns system clock
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    ////////////////////
    // Random source
    ////////////////////

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end else begin
            return state >> 1;
        end
    endfunction

    // One LFSR step per bit taken
    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value[i] = lfsr_q[0];
            lfsr_q   = lfsr_next(lfsr_q);
        end
        return value;
    endfunction

    ////////////////////
    // Checking
    ////////////////////

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    ////////////////////
    // JTAG pin tasks
    ////////////////////

    task automatic wait_clk(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Low half then high half, TDO taken just before the rise
    task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
        tck <= 1'b0;
        tms <= tms_v;
        tdi <= tdi_v;
        wait_clk(HALF_TCK);
        tdo_v = tdo;
        tck <= 1'b1;
        wait_clk(HALF_TCK);
    endtask

    // Five TMS ones reach Test-Logic-Reset, then park in Idle
    task automatic tap_reset();
        logic bit_out;
        repeat (5) tck_cycle(1'b1, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
    endtask

    task automatic ir_scan(input logic [`DTM_IR_LEN-1:0] code);
        logic                   bit_out;
        logic [`DTM_IR_LEN-1:0] ir_out;
        ir_out = '0;
        // Select-DR, Select-IR, Capture-IR, then into Shift-IR
        tck_cycle(1'b1, 1'b0, bit_out);
        tck_cycle(1'b1, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
        for (int i = 0; i < `DTM_IR_LEN; i++) begin
            tck_cycle(i == `DTM_IR_LEN - 1, code[i], bit_out);
            ir_out[i] = bit_out;
        end
        // Update-IR, back to Idle
        tck_cycle(1'b1, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
        // Capture-IR always shows 01 in the low bits
        check_value("ir_capture", 64'(2'b01), 64'(ir_out[1:0]));
    endtask

    // Returns the captured bits, LSB first out of TDO
    task automatic dr_scan(input int n, input logic [63:0] data_in,
                           output logic [63:0] data_out);
        logic bit_out;
        data_out = '0;
        // Select-DR, Capture-DR, then into Shift-DR
        tck_cycle(1'b1, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
        for (int i = 0; i < n; i++) begin
            tck_cycle(i == n - 1, data_in[i], bit_out);
            data_out[i] = bit_out;
        end
        // Update-DR, back to Idle
        tck_cycle(1'b1, 1'b0, bit_out);
        tck_cycle(1'b0, 1'b0, bit_out);
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    function automatic logic [63:0] dmi_word(input logic [`DTM_ABITS-1:0] addr,
                                             input logic [`DTM_DATA_W-1:0] data,
                                             input jtag_dtm_pkg::dmi_op_e op);
        jtag_dtm_pkg::dmi_req_t req;
        req.addr = addr;
        req.data = data;
        req.op   = op;
        return 64'(req);
    endfunction

    // version 1, abits, dmistat, idle 1
    function automatic logic [31:0] dtmcs_expect(input jtag_dtm_pkg::dmi_status_e st);
        logic [31:0] v;
        v        = '0;
        v[3:0]   = 4'd1;
        v[9:4]   = 6'(`DTM_ABITS);
        v[11:10] = st;
        v[14:12] = 3'd1;
        return v;
    endfunction

    // Out of range fails, leaves the words alone and sets sticky FAILED
    task automatic model_access(input jtag_dtm_pkg::dmi_op_e op,
                                input logic [`DTM_ABITS-1:0] addr,
                                input logic [`DTM_DATA_W-1:0] data,
                                output logic [`DTM_DATA_W-1:0] rdata);
        if (addr >= 7'(`DTM_REG_COUNT)) begin
            rdata        = '0;
            model_sticky = jtag_dtm_pkg::DMI_FAILED;
        end else if (op == jtag_dtm_pkg::DMI_WRITE) begin
            model_mem[addr[IDX_W-1:0]] = data;
            rdata                      = data;
        end else begin
            rdata = model_mem[addr[IDX_W-1:0]];
        end
    endtask

    // Request scan, then NOP scans until the capture is no longer BUSY
    task automatic dmi_access(input string name, input jtag_dtm_pkg::dmi_op_e op,
                              input logic [`DTM_ABITS-1:0] addr,
                              input logic [`DTM_DATA_W-1:0] data);
        logic [63:0]            capture;
        logic [`DTM_DATA_W-1:0] rdata;
        logic                   done;
        int                     tries;
        dr_scan(DMI_W, dmi_word(addr, data, op), capture);
        model_access(op, addr, data, rdata);
        done  = 1'b0;
        tries = 0;
        while (!done && tries < BUSY_RETRIES) begin
            // Same address, so the capture keeps it
            dr_scan(DMI_W, dmi_word(addr, '0, jtag_dtm_pkg::DMI_NOP), capture);
            tries++;
            done = (capture[1:0] != jtag_dtm_pkg::DMI_BUSY);
        end
        if (!done) begin
            $display("Timeout: DMI access to address %0d still BUSY after %0d NOP scans",
                     addr, tries);
            abort_run();
        end else begin
            check_value(name, 64'({addr, rdata, model_sticky}), capture);
        end
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin : test_seq
        logic [31:0]            pattern;
        logic [63:0]            captured;
        logic [`DTM_ABITS-1:0]  addr;
        logic [`DTM_DATA_W-1:0] data;

        rst_n <= 1'b0;
        tck   <= 1'b0;
        tms   <= 1'b0;
        tdi   <= 1'b0;
        lfsr_q = 32'd32;
        for (int i = 0; i < `DTM_REG_COUNT; i++) begin
            model_mem[i] = '0;
        end
        model_sticky = jtag_dtm_pkg::DMI_OK;
        wait_clk(RST_CYCLES);
        rst_n <= 1'b1;
        wait_clk(1);

        // IDCODE is selected straight out of reset
        tap_reset();
        dr_scan(32, '0, captured);
        check_value("idcode_after_reset", 64'(`DTM_IDCODE), captured);

        // One-bit delay through BYPASS and through an unused code
        ir_scan(`DTM_IR_BYPASS);
        pattern = 32'(random_bits(32));
        dr_scan(32, 64'(pattern), captured);
        check_value("bypass_delay", {32'd0, pattern[30:0], 1'b0}, captured);
        ir_scan(5'h0a);
        pattern = 32'(random_bits(32));
        dr_scan(32, 64'(pattern), captured);
        check_value("unused_ir_delay", {32'd0, pattern[30:0], 1'b0}, captured);

        ir_scan(`DTM_IR_DTMCS);
        dr_scan(32, '0, captured);
        check_value("dtmcs_fields", 64'(dtmcs_expect(model_sticky)), captured);

        // In-range writes, then reads against the model
        ir_scan(`DTM_IR_DMI);
        for (int i = 0; i < NUM_ACCESS; i++) begin
            addr = 7'(random_bits(IDX_W));
            data = 32'(random_bits(32));
            dmi_access("dmi_write", jtag_dtm_pkg::DMI_WRITE, addr, data);
        end
        for (int i = 0; i < NUM_ACCESS; i++) begin
            addr = 7'(random_bits(IDX_W));
            dmi_access("dmi_read", jtag_dtm_pkg::DMI_READ, addr, '0);
        end

        // Address past the register file
        addr = 7'd16 + 7'(random_bits(6));
        dmi_access("dmi_read_out_of_range", jtag_dtm_pkg::DMI_READ, addr, '0);

        ir_scan(`DTM_IR_DTMCS);
        dr_scan(32, '0, captured);
        check_value("dtmcs_sticky_failed", 64'(dtmcs_expect(model_sticky)), captured);
        // dmireset in bit 16 takes effect on this update
        dr_scan(32, 64'h1_0000, captured);
        check_value("dtmcs_before_clear", 64'(dtmcs_expect(model_sticky)), captured);
        model_sticky = jtag_dtm_pkg::DMI_OK;
        dr_scan(32, '0, captured);
        check_value("dtmcs_after_clear", 64'(dtmcs_expect(model_sticky)), captured);

        ir_scan(`DTM_IR_DMI);
        addr = 7'(random_bits(IDX_W));
        dmi_access("dmi_read_after_clear", jtag_dtm_pkg::DMI_READ, addr, '0);

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
rtl/jtag_dtm_pkg.sv
rtl/jtag_tap_ctrl.sv
rtl/jtag_dr_chain.sv
rtl/dmi_master.sv
rtl/dm_regfile.sv
rtl/jtag_dtm_top.sv
verification/jtag_dtm_assertions.sv
verification/jtag_dtm_tb.sv

/* run.sh */
#!/bin/sh
# Builds the JTAG DTM testbench with Verilator and runs it

LOG=sim.log
BUILD_DIR=obj_dir
SIM=jtag_dtm_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module jtag_dtm_tb --Mdir "$BUILD_DIR" -o "$SIM" -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
